/* Makefile */
# Verilator simulation of the outbound frame buffer

VERILATOR ?= verilator
TOP       ?= ofm_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* async_fifo/async_fifo.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dual-clock gray pointer fifo
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module async_fifo #(
   parameter int WIDTH     = 8,
   parameter int ADDR_W    = 4,
   parameter int AFULL_LVL = 12
) (
   input  wire logic             wclk,
   input  wire logic             rclk,
   input  wire logic             rst,
   // write side, wclk
   input  wire logic [WIDTH-1:0] wdata,
   input  wire logic             winc,
   output logic                  w_almost_full,
   // read side, rclk
   output logic      [WIDTH-1:0] rdata,
   output logic                  rempty,
   input  wire logic             rinc
);

   logic [WIDTH-1:0] mem [2**ADDR_W];

   // write domain
   logic [ADDR_W:0] wbin;
   logic [ADDR_W:0] wgray;
   logic [ADDR_W:0] wbin_next;
   logic [ADDR_W:0] wgray_next;
   logic [ADDR_W:0] wq1_rgray;
   logic [ADDR_W:0] wq2_rgray;
   logic [ADDR_W:0] wq2_rbin;
   logic [ADDR_W:0] wfill;
   logic            wfull;
   logic            wen;

   // read domain
   logic            rrst_meta;
   logic            rrst;
   logic [ADDR_W:0] rbin;
   logic [ADDR_W:0] rgray;
   logic [ADDR_W:0] rbin_next;
   logic [ADDR_W:0] rgray_next;
   logic [ADDR_W:0] rq1_wgray;
   logic [ADDR_W:0] rq2_wgray;
   logic            ren;

   function automatic logic [ADDR_W:0] gray2bin(input logic [ADDR_W:0] g);
      logic [ADDR_W:0] b;
      b[ADDR_W] = g[ADDR_W];
      for (int i = ADDR_W - 1; i >= 0; i--) begin
         b[i] = b[i+1] ^ g[i];
      end
      return b;
   endfunction

   // write pointer, wrap bit on top
   assign wen        = winc && !wfull;
   assign wbin_next  = wbin + {{ADDR_W{1'b0}}, wen};
   assign wgray_next = (wbin_next >> 1) ^ wbin_next;

   always_ff @(posedge wclk) begin
      if (wen) begin
         mem[wbin[ADDR_W-1:0]] <= wdata;
      end
   end

   always_ff @(posedge wclk) begin
      if (rst) begin
         wbin      <= '0;
         wgray     <= '0;
         wfull     <= 1'b0;
         wq1_rgray <= '0;
         wq2_rgray <= '0;
      end else begin
         wbin      <= wbin_next;
         wgray     <= wgray_next;
         // full when the two msbs differ and the rest match
         wfull     <= (wgray_next ==
                       {~wq2_rgray[ADDR_W:ADDR_W-1], wq2_rgray[ADDR_W-2:0]});
         wq1_rgray <= rgray;
         wq2_rgray <= wq1_rgray;
      end
   end

   // fill level seen by the writer, pessimistic by the sync delay
   assign wq2_rbin      = gray2bin(wq2_rgray);
   assign wfill         = wbin - wq2_rbin;
   assign w_almost_full = (wfill >= (ADDR_W + 1)'(AFULL_LVL));

   // reset into rclk, two stages
   always_ff @(posedge rclk) begin
      rrst_meta <= rst;
      rrst      <= rrst_meta;
   end

   assign ren        = rinc && !rempty;
   assign rbin_next  = rbin + {{ADDR_W{1'b0}}, ren};
   assign rgray_next = (rbin_next >> 1) ^ rbin_next;

   always_ff @(posedge rclk) begin
      if (rrst) begin
         rbin      <= '0;
         rgray     <= '0;
         rempty    <= 1'b1;
         rq1_wgray <= '0;
         rq2_wgray <= '0;
      end else begin
         rbin      <= rbin_next;
         rgray     <= rgray_next;
         rempty    <= (rgray_next == rq2_wgray);
         rq1_wgray <= wgray;
         rq2_wgray <= rq1_wgray;
      end
   end

   // head entry shown directly
   assign rdata = mem[rbin[ADDR_W-1:0]];

   a_no_wr_full: assert property (@(posedge wclk) disable iff (rst) !(winc && wfull));
   a_no_rd_empty: assert property (@(posedge rclk) disable iff (rrst) !(rinc && rempty));

endmodule

`default_nettype wire

/* common/ofm_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// outbound frame buffer definitions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package ofm_pkg;

   // payload beat
   localparam int BEAT_W     = 64;
   localparam int KEEP_W     = 8;
   localparam int KEEP_SEL_W = $clog2(KEEP_W);

   // transmit word, last / keep / data from msb down
   localparam int TX_W        = 73;
   localparam int TX_KEEP_LSB = BEAT_W;
   localparam int TX_LAST_BIT = BEAT_W + KEEP_W;

   // descriptor fields
   localparam int CTRL_W        = 17;
   localparam int DESC_LEN_LSB  = 0;
   localparam int DESC_LEN_MSB  = 15;
   localparam int DESC_LEN_W    = DESC_LEN_MSB - DESC_LEN_LSB + 1;
   localparam int DESC_DROP_BIT = 16;
   // beats per frame, length rounded up
   localparam int BCNT_W        = DESC_LEN_W - KEEP_SEL_W + 1;

   // fifo depths as address bits
   localparam int CTRL_AW = 8;
   localparam int DATA_AW = 9;
   localparam int TX_AW   = 9;

   // almost-full thresholds in entries
   localparam int CTRL_AFULL_LVL = 248;
   localparam int DATA_AFULL_LVL = 496;
   localparam int TX_AFULL_LVL   = 500;

   // frame builder states
   localparam logic [1:0] FB_IDLE   = 2'd0;
   localparam logic [1:0] FB_LOAD   = 2'd1;
   localparam logic [1:0] FB_STREAM = 2'd2;

endpackage

`default_nettype wire

/* flist.f */
common/ofm_pkg.sv
async_fifo/async_fifo.sv
source/sync_fifo.sv
source/frame_builder.sv
source/ofm_fifo.sv
source/ofm_tx_top.sv
tests/ofm_checker.sv
tests/ofm_tb.sv

/* source/frame_builder.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// transmit frame builder
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module frame_builder
   import ofm_pkg::*;
(
   input  wire logic              tx_clk,
   input  wire logic              rst,
   // descriptor fifo
   input  wire logic [CTRL_W-1:0] ctrl_fifo_rdata,
   input  wire logic              ctrl_fifo_empty,
   output logic                   ctrl_fifo_rden,
   // payload fifo
   input  wire logic [BEAT_W-1:0] data_fifo_rdata,
   input  wire logic              data_fifo_empty,
   output logic                   data_fifo_rden,
   // transmit fifo
   input  wire logic              tx_fifo_afull,
   output logic      [TX_W-1:0]   tx_fifo_wdata,
   output logic                   tx_fifo_wren
);

   logic [1:0]            state;
   logic [BCNT_W-1:0]     beats_left;
   logic                  drop_q;
   logic [KEEP_W-1:0]     last_keep;
   logic [DESC_LEN_W-1:0] desc_len;
   logic [DESC_LEN_W:0]   len_round;
   logic [KEEP_SEL_W-1:0] len_tail;
   logic                  beat_take;
   logic                  last_beat;

   // descriptor decode
   assign desc_len  = ctrl_fifo_rdata[DESC_LEN_MSB:DESC_LEN_LSB];
   assign len_round = {1'b0, desc_len} + (DESC_LEN_W + 1)'(KEEP_W - 1);
   assign len_tail  = desc_len[KEEP_SEL_W-1:0];

   // pop requests leave ungated
   // the buffer block gates them with not empty
   assign ctrl_fifo_rden = (state == FB_LOAD);
   assign data_fifo_rden = (state == FB_STREAM) && !tx_fifo_afull;
   // a beat actually leaves the data fifo
   assign beat_take      = data_fifo_rden && !data_fifo_empty;
   assign last_beat      = (beats_left == BCNT_W'(1));

   // dropped frames are drained but not written
   assign tx_fifo_wren                              = beat_take && !drop_q;
   assign tx_fifo_wdata[BEAT_W-1:0]                 = data_fifo_rdata;
   assign tx_fifo_wdata[TX_LAST_BIT-1:TX_KEEP_LSB] = last_beat ? last_keep : '1;
   assign tx_fifo_wdata[TX_LAST_BIT]                = last_beat;

   always_ff @(posedge tx_clk) begin
      if (rst) begin
         state <= FB_IDLE;
      end else begin
         case (state)
            FB_IDLE: begin
               if (!ctrl_fifo_empty) begin
                  state <= FB_LOAD;
               end
            end
            FB_LOAD: begin
               state <= FB_STREAM;
            end
            FB_STREAM: begin
               // chain straight into the next descriptor if one waits
               if (beat_take && last_beat) begin
                  state <= ctrl_fifo_empty ? FB_IDLE : FB_LOAD;
               end
            end
            default: begin
               state <= FB_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge tx_clk) begin
      if (rst) begin
         drop_q <= 1'b0;
      end else if (state == FB_LOAD) begin
         drop_q <= ctrl_fifo_rdata[DESC_DROP_BIT];
      end
   end

   // beat counter and final keep
   always_ff @(posedge tx_clk) begin
      if (state == FB_LOAD) begin
         beats_left <= len_round[DESC_LEN_W:KEEP_SEL_W];
         // all lanes when the length is a multiple of 8
         last_keep  <= (len_tail == '0) ? '1 : ~({KEEP_W{1'b1}} << len_tail);
      end else if (beat_take) begin
         beats_left <= beats_left - BCNT_W'(1);
      end
   end

   // writer must never post a zero length descriptor
   a_len_nonzero: assert property (@(posedge tx_clk) disable iff (rst)
      (state == FB_LOAD) |-> (desc_len != '0));

endmodule

`default_nettype wire

/* source/ofm_fifo.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// outbound frame buffer fifos
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module ofm_fifo
   import ofm_pkg::*;
(
   input  wire logic              mm2s_clk,
   input  wire logic              tx_clk,
   input  wire logic              rst,
   // descriptor fifo
   input  wire logic [CTRL_W-1:0] ctrl_fifo_wdata,
   input  wire logic              ctrl_fifo_wren,
   output logic                   ctrl_fifo_afull,
   output logic      [CTRL_W-1:0] ctrl_fifo_rdata,
   output logic                   ctrl_fifo_empty,
   input  wire logic              ctrl_fifo_rden,
   // payload fifo
   input  wire logic [BEAT_W-1:0] data_fifo_wdata,
   input  wire logic              data_fifo_wren,
   output logic                   data_fifo_afull,
   output logic      [BEAT_W-1:0] data_fifo_rdata,
   output logic                   data_fifo_empty,
   input  wire logic              data_fifo_rden,
   // transmit fifo write side
   input  wire logic [TX_W-1:0]   tx_fifo_wdata,
   input  wire logic              tx_fifo_wren,
   output logic                   tx_fifo_afull,
   // mac stream
   output logic      [BEAT_W-1:0] tx_axis_mac_tdata,
   output logic      [KEEP_W-1:0] tx_axis_mac_tkeep,
   output logic                   tx_axis_mac_tlast,
   output logic                   tx_axis_mac_tuser,
   output logic                   tx_axis_mac_tvalid,
   input  wire logic              tx_axis_mac_tready
);

   logic [TX_W-1:0] tx_fifo_rdata;
   logic            tx_fifo_empty;
   logic            tx_fifo_rden;

   // 256 descriptors
   async_fifo #(.WIDTH(CTRL_W), .ADDR_W(CTRL_AW), .AFULL_LVL(CTRL_AFULL_LVL)) info_fifo (
      .wclk          (mm2s_clk),
      .rclk          (tx_clk),
      .rst           (rst),
      .wdata         (ctrl_fifo_wdata),
      .winc          (ctrl_fifo_wren),
      .w_almost_full (ctrl_fifo_afull),
      .rdata         (ctrl_fifo_rdata),
      .rempty        (ctrl_fifo_empty),
      .rinc          (ctrl_fifo_rden && !ctrl_fifo_empty)
   );

   // 512 beats, 4 KB of payload
   async_fifo #(.WIDTH(BEAT_W), .ADDR_W(DATA_AW), .AFULL_LVL(DATA_AFULL_LVL)) data_fifo (
      .wclk          (mm2s_clk),
      .rclk          (tx_clk),
      .rst           (rst),
      .wdata         (data_fifo_wdata),
      .winc          (data_fifo_wren),
      .w_almost_full (data_fifo_afull),
      .rdata         (data_fifo_rdata),
      .rempty        (data_fifo_empty),
      .rinc          (data_fifo_rden && !data_fifo_empty)
   );

   sync_fifo #(.WIDTH(TX_W), .ADDR_W(TX_AW), .AFULL_LVL(TX_AFULL_LVL)) txda_fifo (
      .clk         (tx_clk),
      .rst         (rst),
      .wdata       (tx_fifo_wdata),
      .wren        (tx_fifo_wren),
      .rden        (tx_fifo_rden),
      .rdata       (tx_fifo_rdata),
      .empty       (tx_fifo_empty),
      .almost_full (tx_fifo_afull)
   );

   // split the head word onto the mac port
   assign tx_axis_mac_tdata  = tx_fifo_rdata[BEAT_W-1:0];
   assign tx_axis_mac_tkeep  = tx_fifo_rdata[TX_LAST_BIT-1:TX_KEEP_LSB];
   assign tx_axis_mac_tlast  = tx_fifo_rdata[TX_LAST_BIT];
   // no error signalling
   assign tx_axis_mac_tuser  = 1'b0;
   assign tx_axis_mac_tvalid = !tx_fifo_empty;
   assign tx_fifo_rden       = tx_axis_mac_tvalid && tx_axis_mac_tready;

   // stalled word stays put until the mac takes it
   a_hold_on_stall: assert property (@(posedge tx_clk) disable iff (rst)
      (tx_axis_mac_tvalid && !tx_axis_mac_tready) |=>
      (tx_axis_mac_tvalid && $stable(tx_fifo_rdata)));

endmodule

`default_nettype wire

/* source/ofm_tx_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// outbound frame buffer top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module ofm_tx_top
   import ofm_pkg::*;
(
   input  wire logic              mm2s_clk,
   input  wire logic              tx_clk,
   input  wire logic              rst,
   // dma writer side
   input  wire logic [CTRL_W-1:0] ctrl_fifo_wdata,
   input  wire logic              ctrl_fifo_wren,
   output logic                   ctrl_fifo_afull,
   input  wire logic [BEAT_W-1:0] data_fifo_wdata,
   input  wire logic              data_fifo_wren,
   output logic                   data_fifo_afull,
   // mac side
   output logic      [BEAT_W-1:0] tx_axis_mac_tdata,
   output logic      [KEEP_W-1:0] tx_axis_mac_tkeep,
   output logic                   tx_axis_mac_tlast,
   output logic                   tx_axis_mac_tuser,
   output logic                   tx_axis_mac_tvalid,
   input  wire logic              tx_axis_mac_tready
);

   // builder to buffer, tx_clk
   logic [CTRL_W-1:0] ctrl_fifo_rdata;
   logic              ctrl_fifo_empty;
   logic              ctrl_fifo_rden;
   logic [BEAT_W-1:0] data_fifo_rdata;
   logic              data_fifo_empty;
   logic              data_fifo_rden;
   logic [TX_W-1:0]   tx_fifo_wdata;
   logic              tx_fifo_wren;
   logic              tx_fifo_afull;

   ofm_fifo buf0 (
      .mm2s_clk           (mm2s_clk),
      .tx_clk             (tx_clk),
      .rst                (rst),
      .ctrl_fifo_wdata    (ctrl_fifo_wdata),
      .ctrl_fifo_wren     (ctrl_fifo_wren),
      .ctrl_fifo_afull    (ctrl_fifo_afull),
      .ctrl_fifo_rdata    (ctrl_fifo_rdata),
      .ctrl_fifo_empty    (ctrl_fifo_empty),
      .ctrl_fifo_rden     (ctrl_fifo_rden),
      .data_fifo_wdata    (data_fifo_wdata),
      .data_fifo_wren     (data_fifo_wren),
      .data_fifo_afull    (data_fifo_afull),
      .data_fifo_rdata    (data_fifo_rdata),
      .data_fifo_empty    (data_fifo_empty),
      .data_fifo_rden     (data_fifo_rden),
      .tx_fifo_wdata      (tx_fifo_wdata),
      .tx_fifo_wren       (tx_fifo_wren),
      .tx_fifo_afull      (tx_fifo_afull),
      .tx_axis_mac_tdata  (tx_axis_mac_tdata),
      .tx_axis_mac_tkeep  (tx_axis_mac_tkeep),
      .tx_axis_mac_tlast  (tx_axis_mac_tlast),
      .tx_axis_mac_tuser  (tx_axis_mac_tuser),
      .tx_axis_mac_tvalid (tx_axis_mac_tvalid),
      .tx_axis_mac_tready (tx_axis_mac_tready)
   );

   frame_builder fb0 (
      .tx_clk          (tx_clk),
      .rst             (rst),
      .ctrl_fifo_rdata (ctrl_fifo_rdata),
      .ctrl_fifo_empty (ctrl_fifo_empty),
      .ctrl_fifo_rden  (ctrl_fifo_rden),
      .data_fifo_rdata (data_fifo_rdata),
      .data_fifo_empty (data_fifo_empty),
      .data_fifo_rden  (data_fifo_rden),
      .tx_fifo_afull   (tx_fifo_afull),
      .tx_fifo_wdata   (tx_fifo_wdata),
      .tx_fifo_wren    (tx_fifo_wren)
   );

endmodule

`default_nettype wire

/* source/sync_fifo.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// single-clock fwft fifo
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module sync_fifo #(
   parameter int WIDTH     = 8,
   parameter int ADDR_W    = 4,
   parameter int AFULL_LVL = 12
) (
   input  wire logic             clk,
   input  wire logic             rst,
   input  wire logic [WIDTH-1:0] wdata,
   input  wire logic             wren,
   input  wire logic             rden,
   output logic      [WIDTH-1:0] rdata,
   output logic                  empty,
   output logic                  almost_full
);

   logic [WIDTH-1:0]  mem [2**ADDR_W];
   logic [ADDR_W-1:0] wr_ptr;
   logic [ADDR_W-1:0] rd_ptr;
   // one extra bit, msb set means full
   logic [ADDR_W:0]   count;
   logic              do_rd;

   assign do_rd = rden && !empty;

   always_ff @(posedge clk) begin
      if (wren) begin
         mem[wr_ptr] <= wdata;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wren) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({wren, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // head word visible one clock after the write
   assign rdata       = mem[rd_ptr];
   assign empty       = (count == '0);
   assign almost_full = (count >= (ADDR_W + 1)'(AFULL_LVL));

   a_no_overflow: assert property (@(posedge clk) disable iff (rst) wren |-> !count[ADDR_W]);

endmodule

`default_nettype wire

/* tests/ofm_checker.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mac port checker
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module ofm_checker
   import ofm_pkg::*;
#(
   parameter int NUM_FRAMES = 12
) (
   input  wire logic                                  mm2s_clk,
   input  wire logic                                  tx_clk,
   input  wire logic                                  rst,
   // mac stream
   input  wire logic [BEAT_W-1:0]                     tx_axis_mac_tdata,
   input  wire logic [KEEP_W-1:0]                     tx_axis_mac_tkeep,
   input  wire logic                                  tx_axis_mac_tlast,
   input  wire logic                                  tx_axis_mac_tuser,
   input  wire logic                                  tx_axis_mac_tvalid,
   input  wire logic                                  tx_axis_mac_tready,
   input  wire logic                                  ctrl_fifo_afull,
   input  wire logic                                  data_fifo_afull,
   // frame table
   input  wire logic [NUM_FRAMES-1:0][DESC_LEN_W-1:0] frame_len,
   input  wire logic [NUM_FRAMES-1:0]                 frame_drop,
   input  wire logic [NUM_FRAMES-1:0][DESC_LEN_W-1:0] frame_beats,
   input  wire logic [NUM_FRAMES-1:0][KEEP_W-1:0]     frame_keep,
   // results
   output logic                                       done,
   output int                                         err_count,
   output int                                         frames_checked,
   output int                                         frames_dropped,
   output int                                         beats_seen
);

   localparam logic [31:0] LFSR_SEED = 32'h96d3c590;
   localparam logic [31:0] LFSR_TAPS = 32'h80200003;

   logic [31:0] exp_lfsr;
   int          cur_frame;
   int          beat_idx;
   int          frame_errs;
   bit          reset_checked;
   bit          afull_seen = 1'b0;

   function automatic logic [31:0] lfsr_advance(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
   endfunction

   // same byte order as the writer
   task automatic next_byte(output logic [7:0] value);
      for (int i = 0; i < 8; i++) begin
         value[i] = exp_lfsr[0];
         exp_lfsr = lfsr_advance(exp_lfsr);
      end
   endtask

   task automatic report_mismatch(input string name, input logic [BEAT_W-1:0] got,
                                  input logic [BEAT_W-1:0] exp);
      $display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
      err_count++;
      frame_errs++;
   endtask

   task automatic idle_after_reset();
      if (tx_axis_mac_tvalid !== 1'b0) begin
         report_mismatch("tx_axis_mac_tvalid", BEAT_W'(tx_axis_mac_tvalid), '0);
      end
      if (ctrl_fifo_afull !== 1'b0) begin
         report_mismatch("ctrl_fifo_afull", BEAT_W'(ctrl_fifo_afull), '0);
      end
      if (data_fifo_afull !== 1'b0) begin
         report_mismatch("data_fifo_afull", BEAT_W'(data_fifo_afull), '0);
      end
      if (tx_axis_mac_tuser !== 1'b0) begin
         report_mismatch("tx_axis_mac_tuser", BEAT_W'(tx_axis_mac_tuser), '0);
      end
      $display("reset: idle outputs, %0d errors", frame_errs);
      frame_errs = 0;
   endtask

   // dropped frames burn their payload bytes and produce no beats
   task automatic skip_dropped();
      logic [7:0] unused_byte;
      while (cur_frame < NUM_FRAMES && frame_drop[cur_frame]) begin
         for (int i = 0; i < int'(frame_len[cur_frame]); i++) begin
            next_byte(unused_byte);
         end
         $display("frame %0d: len %0d dropped, no beats expected",
                  cur_frame, frame_len[cur_frame]);
         frames_dropped++;
         cur_frame++;
      end
      if (cur_frame == NUM_FRAMES) begin
         if (!afull_seen) begin
            $display("data_fifo_afull never rose while tx_axis_mac_tready was held low");
            err_count++;
         end
         done = 1'b1;
      end
   endtask

   task automatic check_beat();
      logic [BEAT_W-1:0] exp_data;
      logic [KEEP_W-1:0] exp_keep;
      logic              exp_last;
      logic [7:0]        b;
      int                len;
      int                nbeats;
      if (cur_frame >= NUM_FRAMES) begin
         $display("unexpected beat at %0t after the last frame of the table", $time);
         err_count++;
      end else begin
         len      = int'(frame_len[cur_frame]);
         nbeats   = int'(frame_beats[cur_frame]);
         // unused lanes of the final beat are written as zero
         exp_data = '0;
         for (int lane = 0; lane < KEEP_W; lane++) begin
            if (beat_idx * KEEP_W + lane < len) begin
               next_byte(b);
               exp_data[lane*8 +: 8] = b;
            end
         end
         exp_last = (beat_idx == nbeats - 1);
         exp_keep = exp_last ? frame_keep[cur_frame] : '1;
         if (tx_axis_mac_tdata !== exp_data) begin
            report_mismatch("tx_axis_mac_tdata", tx_axis_mac_tdata, exp_data);
         end
         if (tx_axis_mac_tkeep !== exp_keep) begin
            report_mismatch("tx_axis_mac_tkeep", BEAT_W'(tx_axis_mac_tkeep),
                            BEAT_W'(exp_keep));
         end
         if (tx_axis_mac_tlast !== exp_last) begin
            report_mismatch("tx_axis_mac_tlast", BEAT_W'(tx_axis_mac_tlast),
                            BEAT_W'(exp_last));
         end
         if (tx_axis_mac_tuser !== 1'b0) begin
            report_mismatch("tx_axis_mac_tuser", BEAT_W'(tx_axis_mac_tuser), '0);
         end
         beats_seen++;
         beat_idx++;
         if (exp_last) begin
            $display("frame %0d: len %0d, %0d beats, %0d errors",
                     cur_frame, len, nbeats, frame_errs);
            frames_checked++;
            cur_frame++;
            beat_idx   = 0;
            frame_errs = 0;
            skip_dropped();
         end
      end
   endtask

   // writer side back-pressure seen at least once
   always @(posedge mm2s_clk) begin
      if (!rst && data_fifo_afull) begin
         afull_seen = 1'b1;
      end
   end

   // transfers happen on valid and ready at the rising edge
   always @(posedge tx_clk) begin
      if (rst) begin
         exp_lfsr       = LFSR_SEED;
         cur_frame      = 0;
         beat_idx       = 0;
         frame_errs     = 0;
         reset_checked  = 1'b0;
         done           = 1'b0;
         err_count      = 0;
         frames_checked = 0;
         frames_dropped = 0;
         beats_seen     = 0;
      end else if (!reset_checked) begin
         idle_after_reset();
         reset_checked = 1'b1;
         skip_dropped();
      end else if (tx_axis_mac_tvalid && tx_axis_mac_tready) begin
         check_beat();
      end
   end

endmodule

`default_nettype wire

/* tests/ofm_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// outbound frame buffer testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module ofm_tb
   import ofm_pkg::*;
();

   localparam int          NUM_FRAMES = 12;
   localparam logic [31:0] LFSR_SEED  = 32'h96d3c590;
   // x^32 + x^22 + x^2 + x + 1
   localparam logic [31:0] LFSR_TAPS  = 32'h80200003;
   // ready patterns on the mac port
   localparam logic [1:0]  RDY_ON     = 2'd0;
   localparam logic [1:0]  RDY_RAND   = 2'd1;
   localparam logic [1:0]  RDY_HOLD   = 2'd2;

   logic              mm2s_clk;
   logic              tx_clk;
   logic              rst;
   logic [CTRL_W-1:0] ctrl_fifo_wdata;
   logic              ctrl_fifo_wren;
   logic              ctrl_fifo_afull;
   logic [BEAT_W-1:0] data_fifo_wdata;
   logic              data_fifo_wren;
   logic              data_fifo_afull;
   logic [BEAT_W-1:0] tx_axis_mac_tdata;
   logic [KEEP_W-1:0] tx_axis_mac_tkeep;
   logic              tx_axis_mac_tlast;
   logic              tx_axis_mac_tuser;
   logic              tx_axis_mac_tvalid;
   logic              tx_axis_mac_tready = 1'b0;

   // frame table, expected beat count and final keep worked out by hand
   logic [NUM_FRAMES-1:0][DESC_LEN_W-1:0] frame_len;
   logic [NUM_FRAMES-1:0]                 frame_drop;
   logic [NUM_FRAMES-1:0][1:0]            frame_mode;
   logic [NUM_FRAMES-1:0][DESC_LEN_W-1:0] frame_beats;
   logic [NUM_FRAMES-1:0][KEEP_W-1:0]     frame_keep;
   bit                                    table_loaded = 1'b0;

   logic [31:0] wr_lfsr;
   logic [31:0] rdy_lfsr     = LFSR_SEED;
   logic [1:0]  ready_mode;
   logic        hold_release = 1'b0;
   int          stall_cycles;

   logic        chk_done;
   int          chk_errors;
   int          chk_frames;
   int          chk_dropped;
   int          chk_beats;

   ofm_tx_top dut0 (
      .mm2s_clk           (mm2s_clk),
      .tx_clk             (tx_clk),
      .rst                (rst),
      .ctrl_fifo_wdata    (ctrl_fifo_wdata),
      .ctrl_fifo_wren     (ctrl_fifo_wren),
      .ctrl_fifo_afull    (ctrl_fifo_afull),
      .data_fifo_wdata    (data_fifo_wdata),
      .data_fifo_wren     (data_fifo_wren),
      .data_fifo_afull    (data_fifo_afull),
      .tx_axis_mac_tdata  (tx_axis_mac_tdata),
      .tx_axis_mac_tkeep  (tx_axis_mac_tkeep),
      .tx_axis_mac_tlast  (tx_axis_mac_tlast),
      .tx_axis_mac_tuser  (tx_axis_mac_tuser),
      .tx_axis_mac_tvalid (tx_axis_mac_tvalid),
      .tx_axis_mac_tready (tx_axis_mac_tready)
   );

   ofm_checker #(.NUM_FRAMES(NUM_FRAMES)) chk0 (
      .mm2s_clk           (mm2s_clk),
      .tx_clk             (tx_clk),
      .rst                (rst),
      .tx_axis_mac_tdata  (tx_axis_mac_tdata),
      .tx_axis_mac_tkeep  (tx_axis_mac_tkeep),
      .tx_axis_mac_tlast  (tx_axis_mac_tlast),
      .tx_axis_mac_tuser  (tx_axis_mac_tuser),
      .tx_axis_mac_tvalid (tx_axis_mac_tvalid),
      .tx_axis_mac_tready (tx_axis_mac_tready),
      .ctrl_fifo_afull    (ctrl_fifo_afull),
      .data_fifo_afull    (data_fifo_afull),
      .frame_len          (frame_len),
      .frame_drop         (frame_drop),
      .frame_beats        (frame_beats),
      .frame_keep         (frame_keep),
      .done               (chk_done),
      .err_count          (chk_errors),
      .frames_checked     (chk_frames),
      .frames_dropped     (chk_dropped),
      .beats_seen         (chk_beats)
   );

   function automatic logic [31:0] lfsr_advance(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
   endfunction

   // one payload byte, lsb first, one lfsr step per bit
   task automatic next_byte(output logic [7:0] value);
      for (int i = 0; i < 8; i++) begin
         value[i] = wr_lfsr[0];
         wr_lfsr  = lfsr_advance(wr_lfsr);
      end
   endtask

   task automatic set_frame(input int idx, input int len, input bit drop,
                            input logic [1:0] mode, input int beats,
                            input logic [KEEP_W-1:0] keep);
      frame_len[idx]   = DESC_LEN_W'(len);
      frame_drop[idx]  = drop;
      frame_mode[idx]  = mode;
      frame_beats[idx] = DESC_LEN_W'(beats);
      frame_keep[idx]  = keep;
   endtask

   task automatic load_table();
      //        idx   len drop ready    beats  last keep
      set_frame(0,     1, 0, RDY_ON,     1, 8'h01);
      set_frame(1,     7, 0, RDY_ON,     1, 8'h7f);
      set_frame(2,     8, 0, RDY_ON,     1, 8'hff);
      set_frame(3,     9, 1, RDY_ON,     2, 8'h01);
      set_frame(4,    64, 0, RDY_ON,     8, 8'hff);
      set_frame(5,  1500, 0, RDY_RAND, 188, 8'h0f);
      set_frame(6,   100, 1, RDY_RAND,  13, 8'h0f);
      set_frame(7,     9, 0, RDY_RAND,   2, 8'h01);
      set_frame(8,   333, 0, RDY_RAND,  42, 8'h1f);
      // back to back bursts, more than both fifos hold
      set_frame(9,  5000, 0, RDY_HOLD, 625, 8'hff);
      set_frame(10, 4000, 0, RDY_HOLD, 500, 8'hff);
      set_frame(11,   61, 0, RDY_ON,     8, 8'h1f);
   endtask

   function automatic int table_beats();
      int total;
      total = 0;
      for (int i = 0; i < NUM_FRAMES; i++) begin
         total += int'(frame_beats[i]);
      end
      return total;
   endfunction

   task automatic push_desc(input int idx);
      logic [CTRL_W-1:0] desc;
      desc                             = '0;
      desc[DESC_LEN_MSB:DESC_LEN_LSB] = frame_len[idx];
      desc[DESC_DROP_BIT]              = frame_drop[idx];
      while (ctrl_fifo_afull) begin
         @(negedge mm2s_clk);
      end
      ctrl_fifo_wdata = desc;
      ctrl_fifo_wren  = 1'b1;
      @(negedge mm2s_clk);
      ctrl_fifo_wren  = 1'b0;
   endtask

   task automatic push_beat(input logic [BEAT_W-1:0] beat);
      // hold off while the payload fifo is nearly full
      while (data_fifo_afull) begin
         stall_cycles++;
         @(negedge mm2s_clk);
      end
      data_fifo_wdata = beat;
      data_fifo_wren  = 1'b1;
      @(negedge mm2s_clk);
      data_fifo_wren  = 1'b0;
   endtask

   task automatic write_frame(input int idx);
      int                len;
      bit                desc_after;
      logic [BEAT_W-1:0] beat;
      logic [7:0]        b;
      len        = int'(frame_len[idx]);
      // odd short frames post the descriptor after their beats
      // a long frame cannot sit whole in the payload fifo
      desc_after = (idx % 2 == 1) && (len < 512);
      ready_mode = frame_mode[idx];
      if (!desc_after) begin
         push_desc(idx);
      end
      for (int pos = 0; pos < len; pos += KEEP_W) begin
         beat = '0;
         for (int lane = 0; lane < KEEP_W; lane++) begin
            if (pos + lane < len) begin
               next_byte(b);
               beat[lane*8 +: 8] = b;
            end
         end
         push_beat(beat);
      end
      if (desc_after) begin
         push_desc(idx);
      end
   endtask

   initial begin
      mm2s_clk = 1'b0;
      forever #2 mm2s_clk = ~mm2s_clk;
   end

   // tx clock trails by 1 ns
   initial begin
      tx_clk = 1'b0;
      #1;
      forever #2 tx_clk = ~tx_clk;
   end

   // mac ready, driven on the falling tx edge
   always @(negedge tx_clk) begin
      if (rst) begin
         tx_axis_mac_tready <= 1'b0;
      end else begin
         case (ready_mode)
            RDY_RAND: begin
               tx_axis_mac_tready <= rdy_lfsr[0];
               rdy_lfsr           <= lfsr_advance(rdy_lfsr);
            end
            RDY_HOLD: begin
               // low until the payload fifo backs up into the writer
               tx_axis_mac_tready <= hold_release || data_fifo_afull;
               hold_release       <= hold_release || data_fifo_afull;
            end
            default: begin
               tx_axis_mac_tready <= 1'b1;
            end
         endcase
      end
   end

   initial begin
      rst             = 1'b1;
      ctrl_fifo_wdata = '0;
      ctrl_fifo_wren  = 1'b0;
      data_fifo_wdata = '0;
      data_fifo_wren  = 1'b0;
      ready_mode      = RDY_ON;
      stall_cycles    = 0;
      wr_lfsr         = LFSR_SEED;
      load_table();
      table_loaded = 1'b1;
      // two whole cycles once the clock runs, covers the tx side reset sync
      @(negedge mm2s_clk);
      repeat (2) @(negedge mm2s_clk);
      rst = 1'b0;
      for (int i = 0; i < NUM_FRAMES; i++) begin
         write_frame(i);
      end
      wait (chk_done);
      // quiet time, a stray beat would still show up
      repeat (50) @(posedge tx_clk);
      $display("summary: %0d frames checked, %0d dropped, %0d beats, %0d stall cycles, %0d errors",
               chk_frames, chk_dropped, chk_beats, stall_cycles, chk_errors);
      if (chk_errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   // watchdog, 40 ns per beat plus 2 us
   initial begin
      int budget_ns;
      wait (table_loaded);
      budget_ns = 40 * table_beats() + 2000;
      #(budget_ns);
      $display("watchdog expired after %0d ns, not every frame reached the MAC port",
               budget_ns);
      $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire
